// ==== src/rv_dec_macros.svh ====
`ifndef RV_DEC_MACROS_SVH
`define RV_DEC_MACROS_SVH

`define INST_LEN   32
`define IMM_LEN    64
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

`define ALUOP_W 5
`define MEMOP_W 4
`define EXCOP_W 4
`define PCOP_W  3
`define CSROP_W 3

// major opcodes, rv64i only
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JALR    7'b1100111
`define OPC_JAL     7'b1101111
`define OPC_OPIMM   7'b0010011
`define OPC_OPIMM32 7'b0011011
`define OPC_OP      7'b0110011
`define OPC_OP32    7'b0111011
`define OPC_SYSTEM  7'b1110011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// imm12 of the func3 == 0 system group
`define SYS_ECALL  12'h000
`define SYS_EBREAK 12'h001
`define SYS_MRET   12'h302

`define ALUOP_NONE 5'd0
`define ALUOP_ADD  5'd1
`define ALUOP_SUB  5'd2
`define ALUOP_XOR  5'd3
`define ALUOP_OR   5'd4
`define ALUOP_AND  5'd5
`define ALUOP_SLL  5'd6
`define ALUOP_SRL  5'd7
`define ALUOP_SRA  5'd8
`define ALUOP_SLLW 5'd9
`define ALUOP_SRLW 5'd10
`define ALUOP_SRAW 5'd11
`define ALUOP_SLT  5'd12
`define ALUOP_SLTU 5'd13
`define ALUOP_BEQ  5'd14
`define ALUOP_BNE  5'd15
`define ALUOP_BLT  5'd16
`define ALUOP_BGE  5'd17
`define ALUOP_BLTU 5'd18
`define ALUOP_BGEU 5'd19

`define MEMOP_NONE 4'd0
`define MEMOP_LB   4'd1
`define MEMOP_LH   4'd2
`define MEMOP_LW   4'd3
`define MEMOP_LD   4'd4
`define MEMOP_LBU  4'd5
`define MEMOP_LHU  4'd6
`define MEMOP_LWU  4'd7
`define MEMOP_SB   4'd8
`define MEMOP_SH   4'd9
`define MEMOP_SW   4'd10
`define MEMOP_SD   4'd11

`define EXCOP_NONE    4'd0
`define EXCOP_AUIPC   4'd1
`define EXCOP_LUI     4'd2
`define EXCOP_JAL     4'd3
`define EXCOP_JALR    4'd4
`define EXCOP_LOAD    4'd5
`define EXCOP_STORE   4'd6
`define EXCOP_BRANCH  4'd7
`define EXCOP_OPIMM   4'd8
`define EXCOP_OPIMM32 4'd9
`define EXCOP_OP      4'd10
`define EXCOP_OP32    4'd11
`define EXCOP_CSR     4'd12
`define EXCOP_EBREAK  4'd13

`define PCOP_INC4   3'd0
`define PCOP_BRANCH 3'd1
`define PCOP_JAL    3'd2
`define PCOP_JALR   3'd3
`define PCOP_MRET   3'd4
`define PCOP_MTVEC  3'd5

`define CSROP_NONE  3'd0
`define CSROP_READ  3'd1
`define CSROP_WRITE 3'd2
`define CSROP_SET   3'd3
`define CSROP_CLEAR 3'd4

`endif

// ==== src/rv_dec_pkg.sv ====
`include "rv_dec_macros.svh"

package rv_dec_pkg;

  typedef logic [`INST_LEN-1:0]   inst_t;
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`IMM_LEN-1:0]    imm_t;

  // OTHER first so a cleared instruction lands there
  typedef enum logic [3:0] {
    GRP_OTHER, GRP_LOAD, GRP_STORE, GRP_BRANCH, GRP_JALR, GRP_JAL, GRP_OPIMM,
    GRP_OPIMM32, GRP_OP, GRP_OP32, GRP_SYSTEM, GRP_LUI, GRP_AUIPC
  } opgrp_e;

  typedef enum logic [5:0] {
    K_INVALID,
    K_LUI, K_AUIPC, K_JAL, K_JALR,
    K_BEQ, K_BNE, K_BLT, K_BGE, K_BLTU, K_BGEU,
    K_LB, K_LH, K_LW, K_LD, K_LBU, K_LHU, K_LWU,
    K_SB, K_SH, K_SW, K_SD,
    K_ADDI, K_SLTI, K_SLTIU, K_XORI, K_ORI, K_ANDI, K_SLLI, K_SRLI, K_SRAI,
    K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU, K_XOR, K_SRL, K_SRA, K_OR, K_AND,
    K_ADDIW, K_SLLIW, K_SRLIW, K_SRAIW,
    K_ADDW, K_SUBW, K_SLLW, K_SRLW, K_SRAW,
    K_ECALL, K_EBREAK, K_MRET,
    K_CSRRW, K_CSRRS, K_CSRRC, K_CSRRWI, K_CSRRSI, K_CSRRCI
  } inst_kind_e;

  typedef enum logic [2:0] {
    FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
  } fmt_e;

  typedef enum logic [`ALUOP_W-1:0] {
    ALU_NONE = `ALUOP_NONE, ALU_ADD = `ALUOP_ADD, ALU_SUB = `ALUOP_SUB,
    ALU_XOR = `ALUOP_XOR, ALU_OR = `ALUOP_OR, ALU_AND = `ALUOP_AND,
    ALU_SLL = `ALUOP_SLL, ALU_SRL = `ALUOP_SRL, ALU_SRA = `ALUOP_SRA,
    ALU_SLLW = `ALUOP_SLLW, ALU_SRLW = `ALUOP_SRLW, ALU_SRAW = `ALUOP_SRAW,
    ALU_SLT = `ALUOP_SLT, ALU_SLTU = `ALUOP_SLTU, ALU_BEQ = `ALUOP_BEQ,
    ALU_BNE = `ALUOP_BNE, ALU_BLT = `ALUOP_BLT, ALU_BGE = `ALUOP_BGE,
    ALU_BLTU = `ALUOP_BLTU, ALU_BGEU = `ALUOP_BGEU
  } alu_op_e;

  typedef enum logic [`MEMOP_W-1:0] {
    MEM_NONE = `MEMOP_NONE, MEM_LB = `MEMOP_LB, MEM_LH = `MEMOP_LH,
    MEM_LW = `MEMOP_LW, MEM_LD = `MEMOP_LD, MEM_LBU = `MEMOP_LBU,
    MEM_LHU = `MEMOP_LHU, MEM_LWU = `MEMOP_LWU, MEM_SB = `MEMOP_SB,
    MEM_SH = `MEMOP_SH, MEM_SW = `MEMOP_SW, MEM_SD = `MEMOP_SD
  } mem_op_e;

  typedef enum logic [`EXCOP_W-1:0] {
    EXC_NONE = `EXCOP_NONE, EXC_AUIPC = `EXCOP_AUIPC, EXC_LUI = `EXCOP_LUI,
    EXC_JAL = `EXCOP_JAL, EXC_JALR = `EXCOP_JALR, EXC_LOAD = `EXCOP_LOAD,
    EXC_STORE = `EXCOP_STORE, EXC_BRANCH = `EXCOP_BRANCH, EXC_OPIMM = `EXCOP_OPIMM,
    EXC_OPIMM32 = `EXCOP_OPIMM32, EXC_OP = `EXCOP_OP, EXC_OP32 = `EXCOP_OP32,
    EXC_CSR = `EXCOP_CSR, EXC_EBREAK = `EXCOP_EBREAK
  } exc_op_e;

  typedef enum logic [`PCOP_W-1:0] {
    PC_INC4 = `PCOP_INC4, PC_BRANCH = `PCOP_BRANCH, PC_JAL = `PCOP_JAL,
    PC_JALR = `PCOP_JALR, PC_MRET = `PCOP_MRET, PC_MTVEC = `PCOP_MTVEC
  } pc_op_e;

  typedef enum logic [`CSROP_W-1:0] {
    CSR_NONE = `CSROP_NONE, CSR_READ = `CSROP_READ, CSR_WRITE = `CSROP_WRITE,
    CSR_SET = `CSROP_SET, CSR_CLEAR = `CSROP_CLEAR
  } csr_op_e;

endpackage

// ==== src/rv_opcode_stage.sv ====
`timescale 1ns/10ps
`include "rv_dec_macros.svh"

module rv_opcode_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_dec_pkg::inst_t  inst,
  output rv_dec_pkg::inst_t  q_inst,
  output rv_dec_pkg::opgrp_e opgrp
);
  import rv_dec_pkg::*;

  logic [6:0] opcode;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q_inst <= '0;
    end else begin
      q_inst <= inst;
    end
  end

  assign opcode = q_inst[6:0];

  always_comb begin
    opgrp = GRP_OTHER;
    // compressed and other 16-bit encodings are not decoded
    if (opcode[1:0] == 2'b11) begin
      case (opcode)
        `OPC_LOAD:    opgrp = GRP_LOAD;
        `OPC_STORE:   opgrp = GRP_STORE;
        `OPC_BRANCH:  opgrp = GRP_BRANCH;
        `OPC_JALR:    opgrp = GRP_JALR;
        `OPC_JAL:     opgrp = GRP_JAL;
        `OPC_OPIMM:   opgrp = GRP_OPIMM;
        `OPC_OPIMM32: opgrp = GRP_OPIMM32;
        `OPC_OP:      opgrp = GRP_OP;
        `OPC_OP32:    opgrp = GRP_OP32;
        `OPC_SYSTEM:  opgrp = GRP_SYSTEM;
        `OPC_LUI:     opgrp = GRP_LUI;
        `OPC_AUIPC:   opgrp = GRP_AUIPC;
        default:      opgrp = GRP_OTHER;
      endcase
    end
  end

endmodule

// ==== src/rv_inst_class.sv ====
`timescale 1ns/10ps
`include "rv_dec_macros.svh"

module rv_inst_class (
  input  rv_dec_pkg::inst_t      q_inst,
  input  rv_dec_pkg::opgrp_e     opgrp,
  output rv_dec_pkg::inst_kind_e kind
);
  import rv_dec_pkg::*;

  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] imm12;
  logic [9:0]  f73;

  assign f3    = q_inst[14:12];
  assign f7    = q_inst[31:25];
  assign imm12 = q_inst[31:20];
  assign f73   = {f7, f3};

  always_comb begin
    kind = K_INVALID;
    case (opgrp)
      GRP_LUI:   kind = K_LUI;
      GRP_AUIPC: kind = K_AUIPC;
      GRP_JAL:   kind = K_JAL;
      GRP_JALR: begin
        if (f3 == 3'b000) begin
          kind = K_JALR;
        end
      end
      GRP_BRANCH: begin
        case (f3)
          3'b000:  kind = K_BEQ;
          3'b001:  kind = K_BNE;
          3'b100:  kind = K_BLT;
          3'b101:  kind = K_BGE;
          3'b110:  kind = K_BLTU;
          3'b111:  kind = K_BGEU;
          default: kind = K_INVALID;
        endcase
      end
      GRP_LOAD: begin
        case (f3)
          3'b000:  kind = K_LB;
          3'b001:  kind = K_LH;
          3'b010:  kind = K_LW;
          3'b011:  kind = K_LD;
          3'b100:  kind = K_LBU;
          3'b101:  kind = K_LHU;
          3'b110:  kind = K_LWU;
          default: kind = K_INVALID;
        endcase
      end
      GRP_STORE: begin
        case (f3)
          3'b000:  kind = K_SB;
          3'b001:  kind = K_SH;
          3'b010:  kind = K_SW;
          3'b011:  kind = K_SD;
          default: kind = K_INVALID;
        endcase
      end
      GRP_OPIMM: begin
        // shamt is six bits on rv64, func7[0] belongs to it
        casez (f73)
          10'b???????_000: kind = K_ADDI;
          10'b???????_010: kind = K_SLTI;
          10'b???????_011: kind = K_SLTIU;
          10'b???????_100: kind = K_XORI;
          10'b???????_110: kind = K_ORI;
          10'b???????_111: kind = K_ANDI;
          10'b000000?_001: kind = K_SLLI;
          10'b000000?_101: kind = K_SRLI;
          10'b010000?_101: kind = K_SRAI;
          default:         kind = K_INVALID;
        endcase
      end
      GRP_OPIMM32: begin
        casez (f73)
          10'b???????_000: kind = K_ADDIW;
          10'b0000000_001: kind = K_SLLIW;
          10'b0000000_101: kind = K_SRLIW;
          10'b0100000_101: kind = K_SRAIW;
          default:         kind = K_INVALID;
        endcase
      end
      GRP_OP: begin
        // mul/div/rem (func7 0000001) fall through to invalid
        case (f73)
          10'b0000000_000: kind = K_ADD;
          10'b0100000_000: kind = K_SUB;
          10'b0000000_001: kind = K_SLL;
          10'b0000000_010: kind = K_SLT;
          10'b0000000_011: kind = K_SLTU;
          10'b0000000_100: kind = K_XOR;
          10'b0000000_101: kind = K_SRL;
          10'b0100000_101: kind = K_SRA;
          10'b0000000_110: kind = K_OR;
          10'b0000000_111: kind = K_AND;
          default:         kind = K_INVALID;
        endcase
      end
      GRP_OP32: begin
        case (f73)
          10'b0000000_000: kind = K_ADDW;
          10'b0100000_000: kind = K_SUBW;
          10'b0000000_001: kind = K_SLLW;
          10'b0000000_101: kind = K_SRLW;
          10'b0100000_101: kind = K_SRAW;
          default:         kind = K_INVALID;
        endcase
      end
      GRP_SYSTEM: begin
        case (f3)
          3'b000: begin
            case (imm12)
              `SYS_ECALL:  kind = K_ECALL;
              `SYS_EBREAK: kind = K_EBREAK;
              `SYS_MRET:   kind = K_MRET;
              default:     kind = K_INVALID;
            endcase
          end
          3'b001:  kind = K_CSRRW;
          3'b010:  kind = K_CSRRS;
          3'b011:  kind = K_CSRRC;
          3'b101:  kind = K_CSRRWI;
          3'b110:  kind = K_CSRRSI;
          3'b111:  kind = K_CSRRCI;
          default: kind = K_INVALID;
        endcase
      end
      default: kind = K_INVALID;
    endcase
  end

endmodule

// ==== src/rv_operand_sel.sv ====
`timescale 1ns/10ps
`include "rv_dec_macros.svh"

module rv_operand_sel (
  input  rv_dec_pkg::inst_t      q_inst,
  input  rv_dec_pkg::opgrp_e     opgrp,
  input  rv_dec_pkg::inst_kind_e kind,
  output rv_dec_pkg::reg_idx_t   rs1_idx,
  output rv_dec_pkg::reg_idx_t   rs2_idx,
  output rv_dec_pkg::reg_idx_t   rd_idx,
  output rv_dec_pkg::imm_t       imm_data,
  output rv_dec_pkg::imm_t       imm_csr,
  output logic                   need_imm_csr,
  output rv_dec_pkg::csr_addr_t  csr_idx
);
  import rv_dec_pkg::*;

  fmt_e fmt;
  logic is_csr;
  logic use_rs1;
  logic use_rs2;
  logic use_rd;
  imm_t imm_i;
  imm_t imm_s;
  imm_t imm_b;
  imm_t imm_u;
  imm_t imm_j;

  always_comb begin
    case (opgrp)
      GRP_OP, GRP_OP32:                          fmt = FMT_R;
      GRP_LOAD, GRP_OPIMM, GRP_OPIMM32, GRP_JALR: fmt = FMT_I;
      GRP_STORE:                                 fmt = FMT_S;
      GRP_BRANCH:                                fmt = FMT_B;
      GRP_LUI, GRP_AUIPC:                        fmt = FMT_U;
      GRP_JAL:                                   fmt = FMT_J;
      default:                                   fmt = FMT_NONE;
    endcase
  end

  // uimm sits in the rs1 slot for the immediate csr forms
  assign need_imm_csr = kind inside {K_CSRRWI, K_CSRRSI, K_CSRRCI};
  assign is_csr = need_imm_csr || (kind inside {K_CSRRW, K_CSRRS, K_CSRRC});

  assign use_rs1 = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) && !need_imm_csr;
  assign use_rs2 = fmt inside {FMT_R, FMT_S, FMT_B};
  assign use_rd  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};

  assign rs1_idx = use_rs1 ? q_inst[19:15] : '0;
  assign rs2_idx = use_rs2 ? q_inst[24:20] : '0;
  assign rd_idx  = use_rd ? q_inst[11:7] : '0;
  assign csr_idx = is_csr ? q_inst[31:20] : '0;

  assign imm_csr = {{(`IMM_LEN - `REG_ADDR_W){1'b0}}, q_inst[19:15]};

  assign imm_i = {{(`IMM_LEN - 12){q_inst[31]}}, q_inst[31:20]};
  assign imm_s = {{(`IMM_LEN - 12){q_inst[31]}}, q_inst[31:25], q_inst[11:7]};
  assign imm_b = {{(`IMM_LEN - 13){q_inst[31]}}, q_inst[31], q_inst[7], q_inst[30:25],
                  q_inst[11:8], 1'b0};
  assign imm_u = {{(`IMM_LEN - 32){q_inst[31]}}, q_inst[31:12], 12'b0};
  assign imm_j = {{(`IMM_LEN - 21){q_inst[31]}}, q_inst[31], q_inst[19:12], q_inst[20],
                  q_inst[30:21], 1'b0};

  always_comb begin
    case (fmt)
      FMT_I:   imm_data = imm_i;
      FMT_S:   imm_data = imm_s;
      FMT_B:   imm_data = imm_b;
      FMT_U:   imm_data = imm_u;
      FMT_J:   imm_data = imm_j;
      default: imm_data = '0;
    endcase
  end

endmodule

// ==== src/rv_op_encode.sv ====
`timescale 1ns/10ps

module rv_op_encode (
  input  rv_dec_pkg::opgrp_e     opgrp,
  input  rv_dec_pkg::inst_kind_e kind,
  input  rv_dec_pkg::reg_idx_t   rs1_field,
  output rv_dec_pkg::alu_op_e    alu_op,
  output rv_dec_pkg::mem_op_e    mem_op,
  output rv_dec_pkg::exc_op_e    exc_op,
  output rv_dec_pkg::pc_op_e     pc_op,
  output rv_dec_pkg::csr_op_e    csr_op
);
  import rv_dec_pkg::*;

  logic is_csr;
  logic rs1_zero;

  assign is_csr   = kind inside {K_CSRRW, K_CSRRS, K_CSRRC, K_CSRRWI, K_CSRRSI, K_CSRRCI};
  assign rs1_zero = (rs1_field == '0);

  // address and link arithmetic all go through the adder
  always_comb begin
    case (kind)
      K_ADD, K_ADDW, K_ADDI, K_ADDIW, K_LUI, K_AUIPC, K_JAL, K_JALR,
      K_LB, K_LH, K_LW, K_LD, K_LBU, K_LHU, K_LWU,
      K_SB, K_SH, K_SW, K_SD,
      K_CSRRW, K_CSRRS, K_CSRRC, K_CSRRWI, K_CSRRSI, K_CSRRCI: alu_op = ALU_ADD;
      K_SUB, K_SUBW:       alu_op = ALU_SUB;
      K_XOR, K_XORI:       alu_op = ALU_XOR;
      K_OR, K_ORI:         alu_op = ALU_OR;
      K_AND, K_ANDI:       alu_op = ALU_AND;
      K_SLL, K_SLLI:       alu_op = ALU_SLL;
      K_SRL, K_SRLI:       alu_op = ALU_SRL;
      K_SRA, K_SRAI:       alu_op = ALU_SRA;
      K_SLLW, K_SLLIW:     alu_op = ALU_SLLW;
      K_SRLW, K_SRLIW:     alu_op = ALU_SRLW;
      K_SRAW, K_SRAIW:     alu_op = ALU_SRAW;
      K_SLT, K_SLTI:       alu_op = ALU_SLT;
      K_SLTU, K_SLTIU:     alu_op = ALU_SLTU;
      K_BEQ:               alu_op = ALU_BEQ;
      K_BNE:               alu_op = ALU_BNE;
      K_BLT:               alu_op = ALU_BLT;
      K_BGE:               alu_op = ALU_BGE;
      K_BLTU:              alu_op = ALU_BLTU;
      K_BGEU:              alu_op = ALU_BGEU;
      default:             alu_op = ALU_NONE;
    endcase
  end

  always_comb begin
    case (kind)
      K_LB:    mem_op = MEM_LB;
      K_LH:    mem_op = MEM_LH;
      K_LW:    mem_op = MEM_LW;
      K_LD:    mem_op = MEM_LD;
      K_LBU:   mem_op = MEM_LBU;
      K_LHU:   mem_op = MEM_LHU;
      K_LWU:   mem_op = MEM_LWU;
      K_SB:    mem_op = MEM_SB;
      K_SH:    mem_op = MEM_SH;
      K_SW:    mem_op = MEM_SW;
      K_SD:    mem_op = MEM_SD;
      default: mem_op = MEM_NONE;
    endcase
  end

  // by group, so m-extension encodings still report OP / OP32
  always_comb begin
    case (opgrp)
      GRP_AUIPC:   exc_op = EXC_AUIPC;
      GRP_LUI:     exc_op = EXC_LUI;
      GRP_JAL:     exc_op = EXC_JAL;
      GRP_JALR:    exc_op = EXC_JALR;
      GRP_LOAD:    exc_op = EXC_LOAD;
      GRP_STORE:   exc_op = EXC_STORE;
      GRP_BRANCH:  exc_op = EXC_BRANCH;
      GRP_OPIMM:   exc_op = EXC_OPIMM;
      GRP_OPIMM32: exc_op = EXC_OPIMM32;
      GRP_OP:      exc_op = EXC_OP;
      GRP_OP32:    exc_op = EXC_OP32;
      GRP_SYSTEM: begin
        if (is_csr) begin
          exc_op = EXC_CSR;
        end else if (kind == K_EBREAK) begin
          exc_op = EXC_EBREAK;
        end else begin
          exc_op = EXC_NONE;
        end
      end
      default:     exc_op = EXC_NONE;
    endcase
  end

  always_comb begin
    if (opgrp == GRP_BRANCH) begin
      pc_op = PC_BRANCH;
    end else if (kind == K_JAL) begin
      pc_op = PC_JAL;
    end else if (kind == K_JALR) begin
      pc_op = PC_JALR;
    end else if (kind == K_MRET) begin
      pc_op = PC_MRET;
    end else if (kind == K_ECALL) begin
      pc_op = PC_MTVEC;
    end else begin
      pc_op = PC_INC4;
    end
  end

  // set/clear with x0 or uimm 0 has no write side effect
  always_comb begin
    case (kind)
      K_CSRRW, K_CSRRWI: csr_op = CSR_WRITE;
      K_CSRRS, K_CSRRSI: csr_op = rs1_zero ? CSR_READ : CSR_SET;
      K_CSRRC, K_CSRRCI: csr_op = rs1_zero ? CSR_READ : CSR_CLEAR;
      default:           csr_op = CSR_NONE;
    endcase
  end

endmodule

// ==== src/rv_dec_out_reg.sv ====
`timescale 1ns/10ps

module rv_dec_out_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_dec_pkg::reg_idx_t  rs1_idx,
  input  rv_dec_pkg::reg_idx_t  rs2_idx,
  input  rv_dec_pkg::reg_idx_t  rd_idx,
  input  rv_dec_pkg::imm_t      imm_data,
  input  rv_dec_pkg::imm_t      imm_csr,
  input  logic                  need_imm_csr,
  input  rv_dec_pkg::csr_addr_t csr_idx,
  input  rv_dec_pkg::alu_op_e   alu_op,
  input  rv_dec_pkg::mem_op_e   mem_op,
  input  rv_dec_pkg::exc_op_e   exc_op,
  input  rv_dec_pkg::pc_op_e    pc_op,
  input  rv_dec_pkg::csr_op_e   csr_op,
  output rv_dec_pkg::reg_idx_t  o_rs1_idx,
  output rv_dec_pkg::reg_idx_t  o_rs2_idx,
  output rv_dec_pkg::reg_idx_t  o_rd_idx,
  output rv_dec_pkg::imm_t      o_imm_data,
  output rv_dec_pkg::imm_t      o_imm_csr,
  output logic                  o_need_imm_csr,
  output rv_dec_pkg::csr_addr_t o_csr_idx,
  output rv_dec_pkg::alu_op_e   o_alu_op,
  output rv_dec_pkg::mem_op_e   o_mem_op,
  output rv_dec_pkg::exc_op_e   o_exc_op,
  output rv_dec_pkg::pc_op_e    o_pc_op,
  output rv_dec_pkg::csr_op_e   o_csr_op
);
  import rv_dec_pkg::*;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rs1_idx      <= '0;
      o_rs2_idx      <= '0;
      o_rd_idx       <= '0;
      o_imm_data     <= '0;
      o_imm_csr      <= '0;
      o_need_imm_csr <= 1'b0;
      o_csr_idx      <= '0;
      o_alu_op       <= ALU_NONE;
      o_mem_op       <= MEM_NONE;
      o_exc_op       <= EXC_NONE;
      o_pc_op        <= PC_INC4;
      o_csr_op       <= CSR_NONE;
    end else begin
      o_rs1_idx      <= rs1_idx;
      o_rs2_idx      <= rs2_idx;
      o_rd_idx       <= rd_idx;
      o_imm_data     <= imm_data;
      o_imm_csr      <= imm_csr;
      o_need_imm_csr <= need_imm_csr;
      o_csr_idx      <= csr_idx;
      o_alu_op       <= alu_op;
      o_mem_op       <= mem_op;
      o_exc_op       <= exc_op;
      o_pc_op        <= pc_op;
      o_csr_op       <= csr_op;
    end
  end

endmodule

// ==== src/rv_decode_top.sv ====
`timescale 1ns/10ps

module rv_decode_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_dec_pkg::inst_t     inst,
  output rv_dec_pkg::reg_idx_t  rs1_idx,
  output rv_dec_pkg::reg_idx_t  rs2_idx,
  output rv_dec_pkg::reg_idx_t  rd_idx,
  output rv_dec_pkg::imm_t      imm_data,
  output rv_dec_pkg::imm_t      imm_csr,
  output logic                  need_imm_csr,
  output rv_dec_pkg::csr_addr_t csr_idx,
  output rv_dec_pkg::alu_op_e   alu_op,
  output rv_dec_pkg::mem_op_e   mem_op,
  output rv_dec_pkg::exc_op_e   exc_op,
  output rv_dec_pkg::pc_op_e    pc_op,
  output rv_dec_pkg::csr_op_e   csr_op
);
  import rv_dec_pkg::*;

  inst_t      q_inst;
  opgrp_e     opgrp;
  inst_kind_e kind;

  // decode results ahead of the output register
  reg_idx_t  d_rs1_idx;
  reg_idx_t  d_rs2_idx;
  reg_idx_t  d_rd_idx;
  imm_t      d_imm_data;
  imm_t      d_imm_csr;
  logic      d_need_imm_csr;
  csr_addr_t d_csr_idx;
  alu_op_e   d_alu_op;
  mem_op_e   d_mem_op;
  exc_op_e   d_exc_op;
  pc_op_e    d_pc_op;
  csr_op_e   d_csr_op;

  rv_opcode_stage i_rv_opcode_stage (
    .clk    (clk),
    .rst_n  (rst_n),
    .inst   (inst),
    .q_inst (q_inst),
    .opgrp  (opgrp)
  );

  rv_inst_class i_rv_inst_class (
    .q_inst (q_inst),
    .opgrp  (opgrp),
    .kind   (kind)
  );

  rv_operand_sel i_rv_operand_sel (
    .q_inst       (q_inst),
    .opgrp        (opgrp),
    .kind         (kind),
    .rs1_idx      (d_rs1_idx),
    .rs2_idx      (d_rs2_idx),
    .rd_idx       (d_rd_idx),
    .imm_data     (d_imm_data),
    .imm_csr      (d_imm_csr),
    .need_imm_csr (d_need_imm_csr),
    .csr_idx      (d_csr_idx)
  );

  rv_op_encode i_rv_op_encode (
    .opgrp     (opgrp),
    .kind      (kind),
    .rs1_field (q_inst[19:15]),
    .alu_op    (d_alu_op),
    .mem_op    (d_mem_op),
    .exc_op    (d_exc_op),
    .pc_op     (d_pc_op),
    .csr_op    (d_csr_op)
  );

  rv_dec_out_reg i_rv_dec_out_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .rs1_idx        (d_rs1_idx),
    .rs2_idx        (d_rs2_idx),
    .rd_idx         (d_rd_idx),
    .imm_data       (d_imm_data),
    .imm_csr        (d_imm_csr),
    .need_imm_csr   (d_need_imm_csr),
    .csr_idx        (d_csr_idx),
    .alu_op         (d_alu_op),
    .mem_op         (d_mem_op),
    .exc_op         (d_exc_op),
    .pc_op          (d_pc_op),
    .csr_op         (d_csr_op),
    .o_rs1_idx      (rs1_idx),
    .o_rs2_idx      (rs2_idx),
    .o_rd_idx       (rd_idx),
    .o_imm_data     (imm_data),
    .o_imm_csr      (imm_csr),
    .o_need_imm_csr (need_imm_csr),
    .o_csr_idx      (csr_idx),
    .o_alu_op       (alu_op),
    .o_mem_op       (mem_op),
    .o_exc_op       (exc_op),
    .o_pc_op        (pc_op),
    .o_csr_op       (csr_op)
  );

endmodule

// ==== bench/rv_decode_asserts.sv ====
`timescale 1ns/10ps

module rv_decode_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input rv_dec_pkg::reg_idx_t  rs1_idx,
  input rv_dec_pkg::reg_idx_t  rs2_idx,
  input rv_dec_pkg::reg_idx_t  rd_idx,
  input rv_dec_pkg::imm_t      imm_data,
  input rv_dec_pkg::imm_t      imm_csr,
  input logic                  need_imm_csr,
  input rv_dec_pkg::csr_addr_t csr_idx,
  input rv_dec_pkg::alu_op_e   alu_op,
  input rv_dec_pkg::mem_op_e   mem_op,
  input rv_dec_pkg::exc_op_e   exc_op,
  input rv_dec_pkg::pc_op_e    pc_op,
  input rv_dec_pkg::csr_op_e   csr_op
);
  import rv_dec_pkg::*;

  int unsigned fail_count = 0;
  logic        all_zero;

  assign all_zero = (rs1_idx == '0) && (rs2_idx == '0) && (rd_idx == '0) &&
                    (imm_data == '0) && (imm_csr == '0) && !need_imm_csr &&
                    (csr_idx == '0) && (alu_op == ALU_NONE) && (mem_op == MEM_NONE) &&
                    (exc_op == EXC_NONE) && (pc_op == PC_INC4) && (csr_op == CSR_NONE);

  // a reset edge and the first edge after release both leave zeros behind
  reset_clears: assert property (@(posedge clk) !rst_n |=> all_zero)
    else begin
      $error("decode outputs not zero after a reset edge");
      fail_count++;
    end

  release_quiet: assert property (@(posedge clk) $rose(rst_n) |=> all_zero)
    else begin
      $error("decode outputs not zero in the second cycle after reset");
      fail_count++;
    end

  mem_is_ld_st: assert property (@(posedge clk) disable iff (!rst_n)
    mem_op != MEM_NONE |-> exc_op inside {EXC_LOAD, EXC_STORE})
    else begin
      $error("mem_op %0d without a load or store exc_op", mem_op);
      fail_count++;
    end

  uimm_no_rs1: assert property (@(posedge clk) disable iff (!rst_n)
    need_imm_csr |-> rs1_idx == '0)
    else begin
      $error("rs1_idx set on an immediate csr form");
      fail_count++;
    end

  csr_op_is_csr: assert property (@(posedge clk) disable iff (!rst_n)
    csr_op != CSR_NONE |-> exc_op == EXC_CSR)
    else begin
      $error("csr_op %0d without exc_op CSR", csr_op);
      fail_count++;
    end

endmodule

bind rv_decode_top rv_decode_asserts i_rv_decode_asserts (.*);

// ==== bench/rv_decode_tb.sv ====
`timescale 1ns/10ps
`include "rv_dec_macros.svh"

module rv_decode_tb;
  import rv_dec_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int NUM_COLS   = 13;
  localparam int MAX_PAT    = 64;
  localparam string PAT_FILE = "bench/rv_decode_patterns.txt";

  logic      clk;
  logic      rst_n;
  inst_t     inst;
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  reg_idx_t  rd_idx;
  imm_t      imm_data;
  imm_t      imm_csr;
  logic      need_imm_csr;
  csr_addr_t csr_idx;
  alu_op_e   alu_op;
  mem_op_e   mem_op;
  exc_op_e   exc_op;
  pc_op_e    pc_op;
  csr_op_e   csr_op;

  // one row of NUM_COLS words per instruction
  logic [`IMM_LEN-1:0] pat_mem [0:MAX_PAT*NUM_COLS-1];
  int   n_pat;
  logic loaded = 1'b0;
  // row index of each instruction in flight or -1 for a cleared slot
  int   exp_q[$];

  rv_decode_top i_rv_decode_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .rd_idx       (rd_idx),
    .imm_data     (imm_data),
    .imm_csr      (imm_csr),
    .need_imm_csr (need_imm_csr),
    .csr_idx      (csr_idx),
    .alu_op       (alu_op),
    .mem_op       (mem_op),
    .exc_op       (exc_op),
    .pc_op        (pc_op),
    .csr_op       (csr_op)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, got %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_imm(input string name, input imm_t exp, input imm_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_csr_addr(input string name, input csr_addr_t exp, input csr_addr_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, got %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s (%0d), got %s (%0d)", name, exp.name(), exp,
               act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_mem(input string name, input mem_op_e exp, input mem_op_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s (%0d), got %s (%0d)", name, exp.name(), exp,
               act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_exc(input string name, input exc_op_e exp, input exc_op_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s (%0d), got %s (%0d)", name, exp.name(), exp,
               act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input pc_op_e exp, input pc_op_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s (%0d), got %s (%0d)", name, exp.name(), exp,
               act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_csr_op(input string name, input csr_op_e exp, input csr_op_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s (%0d), got %s (%0d)", name, exp.name(), exp,
               act.name(), act);
      abort_run();
    end
  endtask

  // a cleared slot expects zero in every column
  function automatic logic [`IMM_LEN-1:0] expect_word(input int idx, input int col);
    if (idx < 0) begin
      return '0;
    end
    return pat_mem[idx*NUM_COLS+col];
  endfunction

  task automatic check_outputs(input int idx);
    string tag;
    if (idx < 0) begin
      tag = "reset";
    end else begin
      tag = $sformatf("pattern %0d inst %h", idx, pat_mem[idx*NUM_COLS][31:0]);
    end
    check_idx({tag, " rs1_idx"}, reg_idx_t'(expect_word(idx, 1)), rs1_idx);
    check_idx({tag, " rs2_idx"}, reg_idx_t'(expect_word(idx, 2)), rs2_idx);
    check_idx({tag, " rd_idx"}, reg_idx_t'(expect_word(idx, 3)), rd_idx);
    check_imm({tag, " imm_data"}, imm_t'(expect_word(idx, 4)), imm_data);
    check_imm({tag, " imm_csr"}, imm_t'(expect_word(idx, 5)), imm_csr);
    check_bit({tag, " need_imm_csr"}, expect_word(idx, 6) != '0, need_imm_csr);
    check_csr_addr({tag, " csr_idx"}, csr_addr_t'(expect_word(idx, 7)), csr_idx);
    check_alu({tag, " alu_op"}, alu_op_e'(expect_word(idx, 8)), alu_op);
    check_mem({tag, " mem_op"}, mem_op_e'(expect_word(idx, 9)), mem_op);
    check_exc({tag, " exc_op"}, exc_op_e'(expect_word(idx, 10)), exc_op);
    check_pc({tag, " pc_op"}, pc_op_e'(expect_word(idx, 11)), pc_op);
    check_csr_op({tag, " csr_op"}, csr_op_e'(expect_word(idx, 12)), csr_op);
  endtask

  // any flagged output property ends the run at once
  always @(i_rv_decode_top.i_rv_decode_asserts.fail_count) begin
    if (i_rv_decode_top.i_rv_decode_asserts.fail_count != 0) begin
      $display("%0d output property violations were flagged",
               i_rv_decode_top.i_rv_decode_asserts.fail_count);
      abort_run();
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((RST_CYCLES + n_pat + 4) * CLK_PERIOD * 2);
    $display("run hung: decode of %0d instructions did not complete in time", n_pat);
    abort_run();
  end

  initial begin : stimulus
    clk   = 1'b0;
    rst_n = 1'b0;
    inst  = '0;

    // upper half all ones marks a word the file did not overwrite
    for (int a = 0; a < MAX_PAT * NUM_COLS; a++) begin
      pat_mem[a] = {32'hffff_ffff, 32'(a)};
    end
    $readmemh(PAT_FILE, pat_mem);
    n_pat = 0;
    while (n_pat < MAX_PAT && pat_mem[n_pat*NUM_COLS][63:32] == 32'h0) begin
      n_pat++;
    end
    if (n_pat == 0) begin
      $display("pattern file %s holds no instructions", PAT_FILE);
      abort_run();
    end
    loaded = 1'b1;

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    check_outputs(-1);

    // reset state and one zero instruction give two quiet cycles after release
    exp_q.push_back(-1);
    rst_n = 1'b1;
    exp_q.push_back(-1);

    for (int i = 0; i < n_pat; i++) begin
      @(negedge clk);
      check_outputs(exp_q.pop_front());
      inst = inst_t'(pat_mem[i*NUM_COLS]);
      exp_q.push_back(i);
    end
    // drain the two stages
    repeat (2) begin
      @(negedge clk);
      check_outputs(exp_q.pop_front());
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== bench/rv_decode_patterns.txt ====
// inst rs1 rs2 rd imm_data imm_csr need_imm_csr csr_idx alu mem exc pc csr
// all hex, op codes by enum value, outputs two cycles after the inst is taken
ffc52283 0a 00 05 fffffffffffffffc 0a 0 000 01 3 5 0 0
00816303 02 00 06 0000000000000008 02 0 000 01 7 5 0 0
fe743823 08 07 00 fffffffffffffff0 08 0 000 01 b 6 0 0
fe208ce3 01 02 00 fffffffffffffff8 01 0 000 0e 0 7 1 0
800001b7 00 00 03 ffffffff80000000 00 0 000 01 0 2 0 0
fffff217 00 00 04 fffffffffffff000 1f 0 000 01 0 1 0 0
801ff0ef 00 00 01 fffffffffffff800 1f 0 000 01 0 3 2 0
00008067 01 00 00 0000000000000000 01 0 000 01 0 4 3 0
002081b3 01 02 03 0000000000000000 01 0 000 01 0 a 0 0
027302b3 06 07 05 0000000000000000 06 0 000 00 0 a 0 0
003000d3 00 00 00 0000000000000000 00 0 000 00 0 0 0 0
40c5d53b 0b 0c 0a 0000000000000000 0b 0 000 0b 0 b 0 0
fff4849b 09 00 09 ffffffffffffffff 09 0 000 01 0 9 0 0
43f2d293 05 00 05 000000000000043f 05 0 000 08 0 8 0 0
00000073 00 00 00 0000000000000000 00 0 000 00 0 0 5 0
00100073 00 00 00 0000000000000000 00 0 000 00 0 d 0 0
30200073 00 00 00 0000000000000000 00 0 000 00 0 0 4 0
340110f3 00 00 00 0000000000000000 02 0 340 01 0 c 0 2
300022f3 00 00 00 0000000000000000 00 0 300 01 0 c 0 1
300322f3 00 00 00 0000000000000000 06 0 300 01 0 c 0 3
30407073 00 00 00 0000000000000000 00 1 304 01 0 c 0 1
305ad3f3 00 00 00 0000000000000000 15 1 305 01 0 c 0 2

// ==== sim.f ====
+incdir+src
src/rv_dec_pkg.sv
src/rv_opcode_stage.sv
src/rv_inst_class.sv
src/rv_operand_sel.sv
src/rv_op_encode.sv
src/rv_dec_out_reg.sv
src/rv_decode_top.sv
bench/rv_decode_asserts.sv
bench/rv_decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_decode_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) from $(FLIST) with $(VERILATOR) and run it"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
